//--- hw/exec_config.svh
// Width settings for the execute stage.
// Include wherever data or shift-amount widths are needed.

`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// ********************************************************************
// datapath sizing
// ********************************************************************

// register, immediate and pc width
`define EXEC_WIDTH 16

// shift and rotate amount, taken from the low bits of operand B
`define EXEC_SHAMT 4

`endif

//--- hw/execPkg.sv
// Opcode and result-class types shared by the execute stage blocks.
// Referenced by scoped name (execPkg::...).

package execPkg;

  // operations understood by the execute stage
  typedef enum logic [4:0] {
    opAdd,
    opSub,   // B minus rs
    opXor,
    opAndn,
    opRol,
    opSll,
    opRor,
    opSrl,
    opSlbi,
    opBtr,
    opLbi,
    opSeq,
    opSlt,
    opSle,
    opSco,   // set on carry out of rs + rt
    opJr,
    opJalr,
    opNop
  } opcodeT;

  // how the final data result is picked
  typedef enum logic [1:0] {
    rcAlu,   // computed by the alu core
    rcSet,   // 0/1 from a compare
    rcPass   // an operand passed straight through
  } resultClassT;

  function automatic resultClassT classOf(opcodeT op);
    resultClassT rc;
    case (op)
      opSeq, opSlt, opSle, opSco:  rc = rcSet;
      opLbi, opJr, opJalr, opNop:  rc = rcPass;
      default:                     rc = rcAlu;
    endcase
    return rc;
  endfunction

endpackage

//--- hw/execBus.sv
// Interfaces between the execute stage blocks.
// opBus carries the decoded operation, aluBus the alu core's results.

`timescale 1ns/100ps
`include "exec_config.svh"

interface opBus;
  execPkg::opcodeT         opcode;
  logic                    useImm;      // operand B from imm instead of rt
  logic [`EXEC_WIDTH-1:0]  rs;
  logic [`EXEC_WIDTH-1:0]  rt;
  logic [`EXEC_WIDTH-1:0]  imm;
  logic [`EXEC_WIDTH-1:0]  pc;
  logic [`EXEC_WIDTH-1:0]  jumpOffset;

  modport aluSide (
    input opcode, useImm, rs, rt, imm
  );

  modport targetSide (
    input opcode, rs, pc, imm, jumpOffset
  );
endinterface

interface aluBus;
  logic [`EXEC_WIDTH-1:0]  aluResult;
  logic                    carryOut;
  logic                    signedOvf;
  execPkg::resultClassT    resultClass;
  execPkg::opcodeT         opcode;      // forwarded for the set and err logic

  modport producer (
    output aluResult, carryOut, signedOvf, resultClass, opcode
  );

  modport consumer (
    input aluResult, carryOut, signedOvf, resultClass, opcode
  );
endinterface

//--- hw/aluCore.sv
// Combinational ALU of the execute stage.
// Picks operands, runs the shared adder, shifter and bit ops, reports flags.

`timescale 1ns/100ps
`include "exec_config.svh"

module aluCore (
  opBus.aluSide    ops,
  aluBus.producer  res
);

  logic [`EXEC_WIDTH-1:0]    opB;
  logic [`EXEC_SHAMT-1:0]    shamt;
  logic                      invertA;
  logic                      useRt;
  logic [`EXEC_WIDTH-1:0]    addA;
  logic [`EXEC_WIDTH-1:0]    addB;
  logic [`EXEC_WIDTH-1:0]    sum;
  logic                      carry;
  logic [2*`EXEC_WIDTH-1:0]  rolWide;
  logic [2*`EXEC_WIDTH-1:0]  rorWide;
  logic [`EXEC_WIDTH-1:0]    btrVal;
  logic [`EXEC_WIDTH-1:0]    slbiVal;
  logic [`EXEC_WIDTH-1:0]    aluResult;

  // ********************************************************************
  // operand selection
  // ********************************************************************

  assign opB   = ops.useImm ? ops.imm : ops.rt;
  assign shamt = opB[`EXEC_SHAMT-1:0];

  // subtract forms run as ~rs + B + 1
  assign invertA = ops.opcode inside {execPkg::opSub, execPkg::opSeq,
                                      execPkg::opSlt, execPkg::opSle};

  // compares and sco always work on rt
  assign useRt = ops.opcode inside {execPkg::opSeq, execPkg::opSlt,
                                    execPkg::opSle, execPkg::opSco};

  // ********************************************************************
  // shared adder
  // ********************************************************************

  assign addA = invertA ? ~ops.rs : ops.rs;
  assign addB = useRt ? ops.rt : opB;

  assign {carry, sum} = {1'b0, addA} + {1'b0, addB}
                      + {{`EXEC_WIDTH{1'b0}}, invertA};

  // ********************************************************************
  // shifter and bit ops
  // ********************************************************************

  // rotating a doubled copy keeps both directions to one shift each
  assign rolWide = {ops.rs, ops.rs} << shamt;
  assign rorWide = {ops.rs, ops.rs} >> shamt;

  always_comb begin
    for (int i = 0; i < `EXEC_WIDTH; i++) begin
      btrVal[i] = ops.rs[`EXEC_WIDTH-1-i];
    end
  end

  assign slbiVal = {ops.rs[`EXEC_WIDTH-9:0], ops.imm[7:0]};  // rs << 8 | imm byte

  // ********************************************************************
  // result select
  // ********************************************************************

  always_comb begin
    case (ops.opcode)
      execPkg::opAdd,
      execPkg::opSub,
      execPkg::opSeq,
      execPkg::opSlt,
      execPkg::opSle,
      execPkg::opSco:  aluResult = sum;
      execPkg::opXor:  aluResult = ops.rs ^ opB;
      execPkg::opAndn: aluResult = ops.rs & ~opB;
      execPkg::opRol:  aluResult = rolWide[2*`EXEC_WIDTH-1:`EXEC_WIDTH];
      execPkg::opSll:  aluResult = ops.rs << shamt;
      execPkg::opRor:  aluResult = rorWide[`EXEC_WIDTH-1:0];
      execPkg::opSrl:  aluResult = ops.rs >> shamt;
      execPkg::opSlbi: aluResult = slbiVal;
      execPkg::opBtr:  aluResult = btrVal;
      execPkg::opLbi:  aluResult = ops.imm;
      execPkg::opJr,
      execPkg::opJalr: aluResult = ops.rs;   // pass-through of the jump base
      default:         aluResult = '0;       // nop
    endcase
  end

  assign res.aluResult = aluResult;
  assign res.carryOut  = carry;

  // operands agree in sign but the sum does not
  assign res.signedOvf = (addA[`EXEC_WIDTH-1] == addB[`EXEC_WIDTH-1])
                       && (sum[`EXEC_WIDTH-1] != addA[`EXEC_WIDTH-1]);

  assign res.resultClass = execPkg::classOf(ops.opcode);
  assign res.opcode      = ops.opcode;

endmodule

//--- hw/targetCalc.sv
// Branch and jump target adders of the execute stage.
// Runs next to the ALU core, purely combinational.

`timescale 1ns/100ps
`include "exec_config.svh"

module targetCalc (
  opBus.targetSide               ops,
  output logic [`EXEC_WIDTH-1:0] branchTarget,
  output logic [`EXEC_WIDTH-1:0] jumpTarget
);

  logic                    regJump;
  logic [`EXEC_WIDTH-1:0]  jumpBase;

  // ********************************************************************
  // branch adder
  // ********************************************************************

  // taken-or-not is decided later; the target is always ready
  assign branchTarget = ops.pc + ops.imm;

  // ********************************************************************
  // jump adder
  // ********************************************************************

  // register-indirect jumps start from rs
  assign regJump = (ops.opcode == execPkg::opJr) || (ops.opcode == execPkg::opJalr);

  assign jumpBase   = regJump ? ops.rs : ops.pc;
  assign jumpTarget = jumpBase + ops.jumpOffset;  // wraps on overflow

endmodule

//--- hw/resultMerge.sv
// Final merge and output register of the execute stage.
// Forms set-condition results and err, then registers all outputs.

`timescale 1ns/100ps
`include "exec_config.svh"

module resultMerge (
  input  logic                   clk,
  input  logic                   arstN,
  input  logic                   inValid,
  aluBus.consumer                res,
  input  logic [`EXEC_WIDTH-1:0] branchTarget,
  input  logic [`EXEC_WIDTH-1:0] jumpTarget,
  output logic [`EXEC_WIDTH-1:0] result,
  output logic                   zero,
  output logic                   ltz,
  output logic [`EXEC_WIDTH-1:0] branchTargetQ,
  output logic [`EXEC_WIDTH-1:0] jumpTargetQ,
  output logic                   err,
  output logic                   outValid
);

  logic                    diffZero;
  logic                    diffNeg;
  logic                    setHit;
  logic [`EXEC_WIDTH-1:0]  nextResult;
  logic                    nextErr;

  // ********************************************************************
  // set conditions
  // ********************************************************************

  // for compares the alu result holds rt - rs
  assign diffZero = (res.aluResult == '0);
  assign diffNeg  = res.aluResult[`EXEC_WIDTH-1] ^ res.signedOvf;  // true sign of rt - rs

  always_comb begin
    case (res.opcode)
      execPkg::opSeq: setHit = diffZero;
      execPkg::opSlt: setHit = !diffNeg && !diffZero;  // rt - rs > 0
      execPkg::opSle: setHit = !diffNeg;
      execPkg::opSco: setHit = res.carryOut;
      default:        setHit = 1'b0;
    endcase
  end

  assign nextResult = (res.resultClass == execPkg::rcSet) ?
                      {{(`EXEC_WIDTH-1){1'b0}}, setHit} : res.aluResult;

  // only add and sub report overflow
  assign nextErr = res.signedOvf
                 && (res.opcode inside {execPkg::opAdd, execPkg::opSub});

  // ********************************************************************
  // output register
  // ********************************************************************

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      outValid      <= 1'b0;
      result        <= '0;
      zero          <= 1'b0;
      ltz           <= 1'b0;
      branchTargetQ <= '0;
      jumpTargetQ   <= '0;
      err           <= 1'b0;
    end else begin
      outValid <= inValid;
      if (inValid) begin  // hold last values on idle cycles
        result        <= nextResult;
        zero          <= (nextResult == '0);
        ltz           <= nextResult[`EXEC_WIDTH-1];
        branchTargetQ <= branchTarget;
        jumpTargetQ   <= jumpTarget;
        err           <= nextErr;
      end
    end
  end

endmodule

//--- hw/execStage.sv
// Top level of the execute stage, one clock of latency.
// Spreads the decoded operation over opBus and joins the three blocks.

`timescale 1ns/100ps
`include "exec_config.svh"

module execStage (
  input  logic                   clk,
  input  logic                   arstN,
  input  logic                   inValid,
  input  execPkg::opcodeT        opcode,
  input  logic                   useImm,
  input  logic [`EXEC_WIDTH-1:0] rs,
  input  logic [`EXEC_WIDTH-1:0] rt,
  input  logic [`EXEC_WIDTH-1:0] imm,
  input  logic [`EXEC_WIDTH-1:0] pc,
  input  logic [`EXEC_WIDTH-1:0] jumpOffset,
  output logic [`EXEC_WIDTH-1:0] result,
  output logic                   zero,
  output logic                   ltz,
  output logic [`EXEC_WIDTH-1:0] branchTarget,
  output logic [`EXEC_WIDTH-1:0] jumpTarget,
  output logic                   err,
  output logic                   outValid
);

  opBus  opIf ();
  aluBus aluIf ();

  logic [`EXEC_WIDTH-1:0] branchNext;  // combinational targets
  logic [`EXEC_WIDTH-1:0] jumpNext;

  assign opIf.opcode     = opcode;
  assign opIf.useImm     = useImm;
  assign opIf.rs         = rs;
  assign opIf.rt         = rt;
  assign opIf.imm        = imm;
  assign opIf.pc         = pc;
  assign opIf.jumpOffset = jumpOffset;

  aluCore aluCore_i (
    .ops (opIf.aluSide),
    .res (aluIf.producer)
  );

  targetCalc targetCalc_i (
    .ops          (opIf.targetSide),
    .branchTarget (branchNext),
    .jumpTarget   (jumpNext)
  );

  resultMerge resultMerge_i (
    .clk           (clk),
    .arstN         (arstN),
    .inValid       (inValid),
    .res           (aluIf.consumer),
    .branchTarget  (branchNext),
    .jumpTarget    (jumpNext),
    .result        (result),
    .zero          (zero),
    .ltz           (ltz),
    .branchTargetQ (branchTarget),
    .jumpTargetQ   (jumpTarget),
    .err           (err),
    .outValid      (outValid)
  );

endmodule

//--- testbench/clockGen.sv
// Clock and reset source for the execute stage testbench.
// 20 ns clock, arstN held low for the first resetCycles rising edges.

`timescale 1ns/100ps

module clockGen #(
  parameter int halfPeriod  = 10,
  parameter int resetCycles = 16
) (
  output logic clk,
  output logic arstN
);

  initial begin
    clk = 1'b0;
    forever #(halfPeriod) clk = ~clk;
  end

  initial begin
    arstN = 1'b0;
    repeat (resetCycles) @(posedge clk);
    arstN <= 1'b1;  // flops still see reset on this edge
  end

endmodule

//--- testbench/execVectors.svh
// Directed rows for the execute stage testbench, one operation per row.
// Included inside execTb, after the row type.

`ifndef EXEC_VECTORS_SVH
`define EXEC_VECTORS_SVH

// each row holds op, useImm, rs, rt, imm, pc, jumpOffset,
// then expected result, branchTarget, jumpTarget and err
localparam int numTableRows = 21;

vecT tableRows [numTableRows] = '{
  '{execPkg::opAdd,  1'b0, 16'h1234, 16'h0F0F, 16'h0010, 16'h0100, 16'h0020,
    16'h2143, 16'h0110, 16'h0120, 1'b0},
  '{execPkg::opAdd,  1'b1, 16'h7FFF, 16'h5A5A, 16'h0001, 16'h0200, 16'h0004,
    16'h8000, 16'h0201, 16'h0204, 1'b1},   // imm picked, overflow
  '{execPkg::opSub,  1'b0, 16'h0005, 16'h0003, 16'h0000, 16'h0300, 16'h0008,
    16'hFFFE, 16'h0300, 16'h0308, 1'b0},
  '{execPkg::opSub,  1'b0, 16'h0001, 16'h8000, 16'hFFFF, 16'h0400, 16'hFFFC,
    16'h7FFF, 16'h03FF, 16'h03FC, 1'b1},
  '{execPkg::opXor,  1'b0, 16'hAAAA, 16'hAAAA, 16'h0002, 16'h0500, 16'h0010,
    16'h0000, 16'h0502, 16'h0510, 1'b0},
  '{execPkg::opAndn, 1'b1, 16'hF0F0, 16'h1111, 16'h00FF, 16'h0600, 16'h0002,
    16'hF000, 16'h06FF, 16'h0602, 1'b0},
  '{execPkg::opRol,  1'b0, 16'h8001, 16'h0001, 16'h0003, 16'h0700, 16'h0040,
    16'h0003, 16'h0703, 16'h0740, 1'b0},
  '{execPkg::opRol,  1'b1, 16'h1234, 16'h000F, 16'h0010, 16'h0800, 16'h0000,
    16'h1234, 16'h0810, 16'h0800, 1'b0},   // amount 0 from imm
  '{execPkg::opSll,  1'b0, 16'h0003, 16'h000F, 16'h0001, 16'h0900, 16'h0001,
    16'h8000, 16'h0901, 16'h0901, 1'b0},
  '{execPkg::opRor,  1'b0, 16'h0001, 16'h0004, 16'h0020, 16'h0A00, 16'h0100,
    16'h1000, 16'h0A20, 16'h0B00, 1'b0},
  '{execPkg::opSrl,  1'b0, 16'h8000, 16'h000F, 16'h0004, 16'h0C00, 16'h0020,
    16'h0001, 16'h0C04, 16'h0C20, 1'b0},
  '{execPkg::opSlbi, 1'b1, 16'h12AB, 16'h0000, 16'h34CD, 16'h0D00, 16'h0030,
    16'hABCD, 16'h41CD, 16'h0D30, 1'b0},
  '{execPkg::opBtr,  1'b0, 16'h1234, 16'h0000, 16'h0006, 16'h0E00, 16'h0002,
    16'h2C48, 16'h0E06, 16'h0E02, 1'b0},
  '{execPkg::opLbi,  1'b1, 16'h5555, 16'h0000, 16'h8421, 16'h0F00, 16'h0004,
    16'h8421, 16'h9321, 16'h0F04, 1'b0},
  '{execPkg::opSeq,  1'b1, 16'h1234, 16'h1234, 16'h0008, 16'h1000, 16'h0010,
    16'h0001, 16'h1008, 16'h1010, 1'b0},   // compares take rt even with useImm
  '{execPkg::opSlt,  1'b0, 16'h8000, 16'h7FFF, 16'h0002, 16'h1100, 16'h0006,
    16'h0001, 16'h1102, 16'h1106, 1'b0},   // difference overflows
  '{execPkg::opSle,  1'b0, 16'h0001, 16'hFFFF, 16'h0004, 16'h1200, 16'h0008,
    16'h0000, 16'h1204, 16'h1208, 1'b0},
  '{execPkg::opSle,  1'b0, 16'hFFFE, 16'hFFFE, 16'h0000, 16'h1300, 16'h0002,
    16'h0001, 16'h1300, 16'h1302, 1'b0},
  '{execPkg::opSco,  1'b0, 16'h8000, 16'h8000, 16'h0010, 16'h1400, 16'h0004,
    16'h0001, 16'h1410, 16'h1404, 1'b0},   // ovf here never reaches err
  '{execPkg::opJr,   1'b0, 16'h2000, 16'h0000, 16'h0004, 16'h1600, 16'h0010,
    16'h2000, 16'h1604, 16'h2010, 1'b0},
  '{execPkg::opJalr, 1'b0, 16'h3000, 16'h0000, 16'h0008, 16'h1700, 16'hFFF0,
    16'h3000, 16'h1708, 16'h2FF0, 1'b0}
};

`endif

//--- testbench/execTb.sv
// Testbench for the execute stage. Table rows and random add/sub rows go in
// back to back, and each row's outputs are checked one cycle later.

`timescale 1ns/100ps
`include "exec_config.svh"

module execTb;

  typedef struct packed {
    execPkg::opcodeT         op;
    logic                    useImm;
    logic [`EXEC_WIDTH-1:0]  rs;
    logic [`EXEC_WIDTH-1:0]  rt;
    logic [`EXEC_WIDTH-1:0]  imm;
    logic [`EXEC_WIDTH-1:0]  pc;
    logic [`EXEC_WIDTH-1:0]  jumpOffset;
    logic [`EXEC_WIDTH-1:0]  expResult;
    logic [`EXEC_WIDTH-1:0]  expBranch;
    logic [`EXEC_WIDTH-1:0]  expJump;
    logic                    expErr;
  } vecT;

  `include "execVectors.svh"

  localparam int numRandomRows = 200;
  localparam int numRows       = numTableRows + numRandomRows;
  localparam int timeoutCycles = 16 + numRows + 50;

  logic                    clk;
  logic                    arstN;
  logic                    inValid;
  execPkg::opcodeT         opcode;
  logic                    useImm;
  logic [`EXEC_WIDTH-1:0]  rs, rt, imm, pc, jumpOffset;
  logic [`EXEC_WIDTH-1:0]  result, branchTarget, jumpTarget;
  logic                    zero, ltz, err, outValid;

  vecT rows [$];
  int  seed = 32'hfe85_1992;
  int  cycleCount = 0;

  clockGen clockGen_i (.clk(clk), .arstN(arstN));

  execStage dut_i (
    .clk(clk), .arstN(arstN), .inValid(inValid), .opcode(opcode), .useImm(useImm),
    .rs(rs), .rt(rt), .imm(imm), .pc(pc), .jumpOffset(jumpOffset),
    .result(result), .zero(zero), .ltz(ltz), .branchTarget(branchTarget),
    .jumpTarget(jumpTarget), .err(err), .outValid(outValid)
  );

  // ********************************************************************
  // reference model and checks
  // ********************************************************************

  // {err, result} for add (rs + B) and sub (B - rs)
  function automatic logic [`EXEC_WIDTH:0] addSubModel(execPkg::opcodeT op, logic selImm,
      logic [`EXEC_WIDTH-1:0] a, logic [`EXEC_WIDTH-1:0] t, logic [`EXEC_WIDTH-1:0] i);
    logic [`EXEC_WIDTH-1:0] b;
    int full;
    b = selImm ? i : t;
    if (op == execPkg::opAdd) full = int'($signed(a)) + int'($signed(b));
    else full = int'($signed(b)) - int'($signed(a));
    return {(full > 32767) || (full < -32768), full[`EXEC_WIDTH-1:0]};
  endfunction

  task automatic checkWord(string testName, string field,
      logic [`EXEC_WIDTH-1:0] expected, logic [`EXEC_WIDTH-1:0] actual);
    assert (actual === expected) else begin
      $display("FAILED %s %s: expected 0x%h, actual 0x%h", testName, field, expected, actual);
      $display("Something failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic checkFlag(string testName, string field, logic expected, logic actual);
    checkWord(testName, field, {{(`EXEC_WIDTH-1){1'b0}}, expected},
              {{(`EXEC_WIDTH-1){1'b0}}, actual});
  endtask

  task automatic checkIdle(string testName);
    checkFlag(testName, "outValid", 1'b0, outValid);
    checkWord(testName, "result", '0, result);
    checkFlag(testName, "err", 1'b0, err);
    checkWord(testName, "branchTarget", '0, branchTarget);
    checkWord(testName, "jumpTarget", '0, jumpTarget);
  endtask

  task automatic checkRow(int idx, vecT v);
    execPkg::opcodeT op;
    string name;
    op = v.op;
    name = $sformatf("row%0d_%s", idx, op.name());
    checkFlag(name, "outValid", 1'b1, outValid);
    checkWord(name, "result", v.expResult, result);
    checkFlag(name, "zero", v.expResult == '0, zero);
    checkFlag(name, "ltz", v.expResult[`EXEC_WIDTH-1], ltz);
    checkWord(name, "branchTarget", v.expBranch, branchTarget);
    checkWord(name, "jumpTarget", v.expJump, jumpTarget);
    checkFlag(name, "err", v.expErr, err);
  endtask

  // ********************************************************************
  // stimulus
  // ********************************************************************

  task automatic buildRandomRows();
    logic [31:0] rnd;
    vecT row;
    for (int n = 0; n < numRandomRows; n++) begin
      rnd = $random(seed);
      row.op = rnd[0] ? execPkg::opAdd : execPkg::opSub;
      row.useImm = rnd[1];
      rnd = $random(seed);
      row.rs = rnd[15:0];
      row.rt = rnd[31:16];
      rnd = $random(seed);
      row.imm = rnd[15:0];
      row.pc = rnd[31:16];
      rnd = $random(seed);
      row.jumpOffset = rnd[15:0];
      {row.expErr, row.expResult} = addSubModel(row.op, row.useImm, row.rs, row.rt, row.imm);
      row.expBranch = row.pc + row.imm;
      row.expJump = row.pc + row.jumpOffset;  // pc based for add and sub
      rows.push_back(row);
    end
  endtask

  task automatic driveRow(vecT v);
    inValid    <= 1'b1;
    opcode     <= v.op;
    useImm     <= v.useImm;
    rs         <= v.rs;
    rt         <= v.rt;
    imm        <= v.imm;
    pc         <= v.pc;
    jumpOffset <= v.jumpOffset;
  endtask

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= timeoutCycles) begin
      $display("timeout: run did not finish within %0d cycles", timeoutCycles);
      $display("Something failed");
      $fatal(1, "timeout");
    end
  end

  initial begin
    inValid = 1'b0;
    opcode = execPkg::opNop;
    useImm = 1'b0;
    rs = '0;
    rt = '0;
    imm = '0;
    pc = '0;
    jumpOffset = '0;
    foreach (tableRows[i]) rows.push_back(tableRows[i]);
    buildRandomRows();

    @(posedge clk);
    @(negedge clk);
    while (!arstN) begin
      checkIdle("inReset");
      @(negedge clk);
    end
    checkIdle("afterReset");

    // row i goes in on this edge, row i-1 shows at the following negedge
    for (int i = 0; i <= numRows; i++) begin
      @(posedge clk);
      if (i < numRows) driveRow(rows[i]);
      else inValid <= 1'b0;
      @(negedge clk);
      if (i > 0) checkRow(i - 1, rows[i - 1]);
    end

    @(negedge clk);  // idle cycle holds the last result
    checkFlag("idleHold", "outValid", 1'b0, outValid);
    checkWord("idleHold", "result", rows[numRows - 1].expResult, result);

    $display("Everything OK");
    $finish;
  end

endmodule

//--- build.f
+incdir+hw
+incdir+testbench
hw/execPkg.sv
hw/execBus.sv
hw/aluCore.sv
hw/targetCalc.sv
hw/resultMerge.sv
hw/execStage.sv
testbench/clockGen.sv
testbench/execTb.sv

//--- run.sh
#!/bin/sh
# Compile the execute stage testbench with Verilator, run it and check the log.

cd "$(dirname "$0")" || exit 1

logFile=sim.log

if ! verilator --binary --timing --assert --timescale 1ns/100ps \
    -f build.f --top-module execTb -Mdir obj_dir -o execTbSim; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/execTbSim > "$logFile" 2>&1
simStatus=$?
cat "$logFile"

if [ "$simStatus" -ne 0 ]; then
  echo "simulation exited with status $simStatus"
  exit 1
fi

if grep -qx "Everything OK" "$logFile"; then
  echo "simulation passed"
  exit 0
fi

echo "pass message not found in $logFile"
exit 1
